// File: logic/search_cfg_pkg.sv
`default_nettype none

package search_cfg_pkg;

	// job field widths
	localparam int DATA_W = 32; // block, times, times_start, left
	localparam int KEY_W = 64;  // seed, key state, cipher block

	// registered rounds in one trip around the ring
	// this is also the number of jobs that can be in flight at once
	localparam int MIX_STAGES = 21;

	// stand-in round: rotate left, then xor the fixed s-box word
	localparam int ROT_AMT = 7;
	localparam logic [KEY_W-1:0] SB_CONST = 64'hE613_DB6D_C11C_4524;

endpackage

`default_nettype wire

// File: logic/search_types_pkg.sv
`default_nettype none

package search_types_pkg;

	import search_cfg_pkg::*;

	// one FIFO word, 160 bits
	typedef struct packed {
		logic [DATA_W-1:0] block;
		logic [KEY_W-1:0]  seed;
		logic [DATA_W-1:0] times;
		logic [DATA_W-1:0] times_start;
	} job_t;

	// search target, compared under mask
	typedef struct packed {
		logic [KEY_W-1:0] mask;
		logic [KEY_W-1:0] value;
	} match_cfg_t;

	// what rides in a ring slot next to the key
	typedef struct packed {
		job_t              job;
		logic [DATA_W-1:0] left; // passes still allowed, never 0 in a live slot
	} ctx_t;

	// reported once per job
	typedef struct packed {
		job_t             job;
		logic [KEY_W-1:0] cb;  // key state after the last pass
		logic             hit;
	} result_t;

endpackage

`default_nettype wire

// File: logic/mix_round_pipe.sv
`default_nettype none

module mix_round_pipe import search_cfg_pkg::*; (
	input  wire              clk,
	input  wire              rst_n,
	input  wire [KEY_W-1:0]  head_key_i,
	output logic [KEY_W-1:0] tail_key_o
);

	// one round of the stand-in cipher
	function automatic logic [KEY_W-1:0] mix_round(input logic [KEY_W-1:0] k);
		logic [KEY_W-1:0] rot;
		rot = {k[KEY_W-ROT_AMT-1:0], k[KEY_W-1:KEY_W-ROT_AMT]};
		return rot ^ SB_CONST;
	endfunction

	logic [KEY_W-1:0] stage_q [MIX_STAGES];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < MIX_STAGES; i++) begin
				stage_q[i] <= '0;
			end
		end else begin
			stage_q[0] <= mix_round(head_key_i); // entry, round 1
			for (int i = 1; i < MIX_STAGES; i++) begin
				stage_q[i] <= mix_round(stage_q[i-1]);
			end
		end
	end

	// MIX_STAGES rounds applied by the time a key gets here
	assign tail_key_o = stage_q[MIX_STAGES-1];

endmodule

`default_nettype wire

// File: logic/ctx_delay_line.sv
`default_nettype none

module ctx_delay_line import search_cfg_pkg::*, search_types_pkg::*; (
	input  wire  clk,
	input  wire  rst_n,
	input  wire  head_valid_i,
	input  ctx_t head_ctx_i,
	output logic tail_valid_o,
	output ctx_t tail_ctx_o
);

	logic valid_q [MIX_STAGES];
	ctx_t ctx_q   [MIX_STAGES];

	// slot occupancy
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < MIX_STAGES; i++) begin
				valid_q[i] <= 1'b0;
			end
		end else begin
			valid_q[0] <= head_valid_i;
			for (int i = 1; i < MIX_STAGES; i++) begin
				valid_q[i] <= valid_q[i-1];
			end
		end
	end

	// job context, only meaningful where valid_q is set
	always_ff @(posedge clk) begin
		ctx_q[0] <= head_ctx_i;
		for (int i = 1; i < MIX_STAGES; i++) begin
			ctx_q[i] <= ctx_q[i-1];
		end
	end

	assign tail_valid_o = valid_q[MIX_STAGES-1];
	assign tail_ctx_o   = ctx_q[MIX_STAGES-1];

	// the head logic must never launch a slot with an exhausted budget
	a_live_slot_has_budget: assert property (@(posedge clk) disable iff (!rst_n)
		tail_valid_o |-> tail_ctx_o.left != '0)
		else $error("live slot at tail with left == 0");

endmodule

`default_nettype wire

// File: logic/loop_ctrl.sv
`default_nettype none

module loop_ctrl import search_cfg_pkg::*, search_types_pkg::*; (
	input  wire              clk,
	input  wire              rst_n,
	input  match_cfg_t       cfg_i,
	// FIFO side
	input  wire              fifo_ready_i,
	input  job_t             fifo_data_i,
	output logic             fifo_ren_o,
	// ring tail
	input  wire              tail_valid_i,
	input  ctx_t             tail_ctx_i,
	input  wire [KEY_W-1:0]  tail_key_i,
	// ring head
	output logic             head_valid_o,
	output ctx_t             head_ctx_o,
	output logic [KEY_W-1:0] head_key_o,
	// results
	output logic             result_valid_o,
	output result_t          result_o
);

	logic              hit;
	logic              budget_done;
	logic              tail_exit;
	logic              tail_loop;
	logic              admit;
	logic [DATA_W-1:0] new_left;

	// compare after every pass
	assign hit = (cfg_i.mask & cfg_i.value) == (cfg_i.mask & tail_key_i);

	assign budget_done = tail_ctx_i.left <= DATA_W'(1);
	assign tail_exit   = tail_valid_i && (hit || budget_done);
	assign tail_loop   = tail_valid_i && !tail_exit;

	// head slot is free when the tail slot leaves or was empty
	assign admit      = !tail_loop && fifo_ready_i;
	assign fifo_ren_o = admit; // fall-through FIFO consumes the word this cycle

	// a fresh job gets at least one pass
	always_comb begin
		if (fifo_data_i.times > fifo_data_i.times_start) begin
			new_left = fifo_data_i.times - fifo_data_i.times_start;
		end else begin
			new_left = DATA_W'(1);
		end
	end

	// head slot loops back, takes a new job or stays empty
	always_comb begin
		head_valid_o = 1'b0;
		head_ctx_o   = tail_ctx_i;
		head_key_o   = tail_key_i;
		if (tail_loop) begin
			head_valid_o    = 1'b1;
			head_ctx_o.left = tail_ctx_i.left - DATA_W'(1);
		end else if (admit) begin
			head_valid_o    = 1'b1;
			head_ctx_o.job  = fifo_data_i;
			head_ctx_o.left = new_left;
			head_key_o      = fifo_data_i.seed ^ KEY_W'(fifo_data_i.block);
		end
	end

	// one-cycle result pulse
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			result_valid_o <= 1'b0;
		end else begin
			result_valid_o <= tail_exit;
		end
	end

	always_ff @(posedge clk) begin
		if (tail_exit) begin
			result_o.job <= tail_ctx_i.job;
			result_o.cb  <= tail_key_i;
			result_o.hit <= hit;
		end
	end

	// a popped job shows up at the tail exactly one ring trip later
	a_pop_reaches_tail: assert property (@(posedge clk) disable iff (!rst_n)
		fifo_ren_o |-> fifo_ready_i ##MIX_STAGES tail_valid_i)
		else $error("popped job did not reach the tail after one pass");

	// every result comes from a slot this head launched one trip earlier
	a_result_from_tail: assert property (@(posedge clk) disable iff (!rst_n)
		result_valid_o |-> $past(tail_valid_i) && $past(head_valid_o, MIX_STAGES + 1) &&
			result_o.job == $past(head_ctx_o.job, MIX_STAGES + 1))
		else $error("result without a matching tail slot");

endmodule

`default_nettype wire

// File: logic/key_search_top.sv
`default_nettype none

module key_search_top import search_cfg_pkg::*, search_types_pkg::*; (
	input  wire        clk,
	input  wire        rst_n,
	input  match_cfg_t cfg_i,
	// job FIFO, first-word fall-through
	input  wire        fifo_ready_i,
	input  job_t       fifo_data_i,
	output logic       fifo_ren_o,
	// result pulse
	output logic       result_valid_o,
	output result_t    result_o
);

	// ring head, driven by loop_ctrl
	logic             head_valid;
	ctx_t             head_ctx;
	logic [KEY_W-1:0] head_key;

	// ring tail, same slot in both pipes
	logic             tail_valid;
	ctx_t             tail_ctx;
	logic [KEY_W-1:0] tail_key;

	loop_ctrl u_loop_ctrl (
		.clk            (clk),
		.rst_n          (rst_n),
		.cfg_i          (cfg_i),
		.fifo_ready_i   (fifo_ready_i),
		.fifo_data_i    (fifo_data_i),
		.fifo_ren_o     (fifo_ren_o),
		.tail_valid_i   (tail_valid),
		.tail_ctx_i     (tail_ctx),
		.tail_key_i     (tail_key),
		.head_valid_o   (head_valid),
		.head_ctx_o     (head_ctx),
		.head_key_o     (head_key),
		.result_valid_o (result_valid_o),
		.result_o       (result_o)
	);

	mix_round_pipe u_mix_round_pipe (
		.clk        (clk),
		.rst_n      (rst_n),
		.head_key_i (head_key),
		.tail_key_o (tail_key)
	);

	ctx_delay_line u_ctx_delay_line (
		.clk          (clk),
		.rst_n        (rst_n),
		.head_valid_i (head_valid),
		.head_ctx_i   (head_ctx),
		.tail_valid_o (tail_valid),
		.tail_ctx_o   (tail_ctx)
	);

endmodule

`default_nettype wire

// File: test/tb_search_model.svh
`ifndef TB_SEARCH_MODEL_SVH
`define TB_SEARCH_MODEL_SVH

logic [31:0] lfsr_state = 32'h4a9704fd;

// rotate left, then the round constant
function automatic logic [KEY_W-1:0] model_round(input logic [KEY_W-1:0] k);
	return ((k << ROT_AMT) | (k >> (KEY_W - ROT_AMT))) ^ SB_CONST;
endfunction

function automatic logic [KEY_W-1:0] model_pass(input logic [KEY_W-1:0] k);
	logic [KEY_W-1:0] r;
	r = k;
	for (int i = 0; i < MIX_STAGES; i++) begin
		r = model_round(r);
	end
	return r;
endfunction

// passes until the target matches or the budget runs out
function automatic void model_run(input job_t job, input match_cfg_t cfg,
	output int passes, output logic [KEY_W-1:0] cb, output logic hit);
	logic [DATA_W-1:0] budget;
	budget = (job.times > job.times_start) ? job.times - job.times_start : DATA_W'(1);
	cb = job.seed ^ KEY_W'(job.block);
	passes = 0;
	hit = 1'b0;
	while (!hit && passes < budget) begin
		cb = model_pass(cb);
		passes++;
		hit = (cfg.mask & cb) == (cfg.mask & cfg.value);
	end
endfunction

// 32-bit fibonacci, taps 32 22 2 1
function automatic logic lfsr_bit();
	logic fb;
	fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
	lfsr_state = {lfsr_state[30:0], fb};
	return fb;
endfunction

function automatic logic [63:0] rand_bits(input int n);
	logic [63:0] r;
	r = '0;
	for (int i = 0; i < n; i++) begin
		r = {r[62:0], lfsr_bit()};
	end
	return r;
endfunction

task automatic check_eq(input string name, input logic [255:0] got, input logic [255:0] exp);
	chk_cnt++;
	if (got !== exp) begin
		err_cnt++;
		$display("FAIL %s: got %h, expected %h", name, got, exp);
	end
endtask

`endif

// File: test/tb_key_search.sv
`default_nettype none

module tb_key_search import search_cfg_pkg::*, search_types_pkg::*;;

	timeunit 1ns;
	timeprecision 1ps;

	logic       clk = 1'b0;
	logic       rst_n = 1'b0;
	match_cfg_t cfg_i = '0;
	logic       fifo_ready_i = 1'b0;
	job_t       fifo_data_i = '0;
	logic       fifo_ren_o;
	logic       result_valid_o;
	result_t    result_o;

	int          err_cnt = 0;
	int          chk_cnt = 0;
	int unsigned cyc = 0;

	job_t              job_q[$]; // FIFO contents
	logic [DATA_W-1:0] pop_blk_q[$];
	int unsigned       pop_cyc_q[$];
	result_t           res_q[$];
	int unsigned       res_cyc_q[$];

	`include "tb_search_model.svh"

	key_search_top i_dut (
		.clk            (clk),
		.rst_n          (rst_n),
		.cfg_i          (cfg_i),
		.fifo_ready_i   (fifo_ready_i),
		.fifo_data_i    (fifo_data_i),
		.fifo_ren_o     (fifo_ren_o),
		.result_valid_o (result_valid_o),
		.result_o       (result_o)
	);

	always #10 clk = ~clk;

	always @(posedge clk) cyc <= cyc + 1;

	// fall-through FIFO and result monitor
	always @(negedge clk) begin
		fifo_ready_i = (job_q.size() != 0);
		fifo_data_i = fifo_ready_i ? job_q[0] : '0;
		#1; // combinational ren settled
		if (rst_n) begin
			if (fifo_ren_o && !fifo_ready_i) begin
				err_cnt++;
				$display("fifo_ren_o went high while the FIFO was empty, cycle %0d", cyc);
			end
			if (fifo_ren_o && fifo_ready_i) begin
				pop_blk_q.push_back(job_q[0].block);
				pop_cyc_q.push_back(cyc);
				job_q.delete(0);
			end
			if (result_valid_o) begin
				res_q.push_back(result_o);
				res_cyc_q.push_back(cyc);
			end
		end
	end

	task automatic clear_records();
		pop_blk_q.delete();
		pop_cyc_q.delete();
		res_q.delete();
		res_cyc_q.delete();
	endtask

	task automatic set_cfg(input logic [KEY_W-1:0] mask, input logic [KEY_W-1:0] value);
		@(negedge clk);
		cfg_i.mask = mask;
		cfg_i.value = value;
	endtask

	task automatic wait_results(input int n, input int max_cycles, input string what);
		int waited;
		waited = 0;
		while (res_q.size() < n && waited < max_cycles) begin
			@(posedge clk);
			waited++;
		end
		if (res_q.size() < n) begin
			err_cnt++;
			$display("timeout in %s: %0d of %0d results after %0d cycles",
				what, res_q.size(), n, max_cycles);
		end
	endtask

	task automatic run_one(input string tag, input job_t job, input int exp_passes,
		input logic [KEY_W-1:0] exp_cb, input logic exp_hit);
		clear_records();
		@(posedge clk);
		job_q.push_back(job);
		wait_results(1, exp_passes * MIX_STAGES + 50, tag);
		if (res_q.size() != 0 && pop_cyc_q.size() != 0) begin
			check_eq({tag, " result_o.job"}, res_q[0].job, job);
			check_eq({tag, " result_o.cb"}, res_q[0].cb, exp_cb);
			check_eq({tag, " result_o.hit"}, res_q[0].hit, exp_hit);
			check_eq({tag, " latency"}, res_cyc_q[0] - pop_cyc_q[0],
				exp_passes * MIX_STAGES + 1);
		end
		repeat (MIX_STAGES + 4) @(posedge clk); // nothing else may come out
		check_eq({tag, " result count"}, res_q.size(), 1);
		check_eq({tag, " pop count"}, pop_cyc_q.size(), 1);
	endtask

	task automatic test_idle_after_reset();
		repeat (100) begin
			@(negedge clk);
			#2;
			check_eq("idle fifo_ren_o", fifo_ren_o, 1'b0);
			check_eq("idle result_valid_o", result_valid_o, 1'b0);
		end
	endtask

	task automatic test_budget_no_hit();
		job_t             job;
		logic [KEY_W-1:0] k;
		job = '{block: 32'h1234_5678, seed: 64'h0f1e_2d3c_4b5a_6978,
			times: 32'd4, times_start: 32'd0};
		k = job.seed ^ KEY_W'(job.block);
		for (int i = 0; i < 4; i++) begin
			k = model_pass(k);
		end
		set_cfg('1, model_pass(k)); // pass five, out of reach
		run_one("budget", job, 4, k, 1'b0);
	endtask

	task automatic test_full_mask_hit();
		job_t             job;
		logic [KEY_W-1:0] p1;
		job = '{block: 32'hcafe_f00d, seed: 64'h8badf00d_00c0ffee, times: 32'd8, times_start: 32'd0};
		p1 = model_pass(job.seed ^ KEY_W'(job.block));
		set_cfg('1, p1);
		run_one("first pass hit", job, 1, p1, 1'b1);
	endtask

	task automatic test_partial_mask_hit();
		job_t             job;
		logic [KEY_W-1:0] p1;
		logic [KEY_W-1:0] p2;
		logic [KEY_W-1:0] p3;
		logic [KEY_W-1:0] m;
		job = '{block: 32'h0bad_beef, seed: 64'h1357_9bdf_2468_ace0, times: 32'd10, times_start: 32'd4};
		p1 = model_pass(job.seed ^ KEY_W'(job.block));
		p2 = model_pass(p1);
		p3 = model_pass(p2);
		// 16-bit window where passes one and two differ from pass three
		m = 64'hFFFF;
		for (int sh = 0; sh <= 48; sh += 4) begin
			m = 64'hFFFF << sh;
			if ((p1 & m) != (p3 & m) && (p2 & m) != (p3 & m)) break;
		end
		set_cfg(m, (p3 & m) | (~m & 64'h5a5a_a5a5_5a5a_a5a5));
		run_one("partial mask", job, 3, p3, 1'b1);
	endtask

	task automatic test_single_pass();
		job_t             job;
		logic [KEY_W-1:0] p1;
		job = '{block: 32'h0000_0042, seed: 64'hfedc_ba98_7654_3210, times: 32'd5, times_start: 32'd5};
		p1 = model_pass(job.seed ^ KEY_W'(job.block));
		set_cfg('1, ~p1);
		run_one("single pass", job, 1, p1, 1'b0);
	endtask

	task automatic test_shared_ring();
		job_t             jobs[20];
		result_t          exp_res[20];
		int               exp_passes[20];
		bit               seen[20];
		int               passes;
		logic [KEY_W-1:0] cb;
		logic             hit;
		int               idx;
		set_cfg(64'h7, 64'h5); // roughly one pass in eight matches
		clear_records();
		for (int i = 0; i < 20; i++) begin
			jobs[i].block = {24'(rand_bits(24)), 8'(i)}; // low byte tags the job
			jobs[i].seed = rand_bits(64);
			jobs[i].times_start = 32'(rand_bits(4));
			jobs[i].times = jobs[i].times_start + 32'(rand_bits(3));
			model_run(jobs[i], cfg_i, passes, cb, hit);
			exp_res[i] = '{job: jobs[i], cb: cb, hit: hit};
			exp_passes[i] = passes;
			seen[i] = 1'b0;
		end
		@(posedge clk);
		for (int i = 0; i < 20; i++) begin
			job_q.push_back(jobs[i]);
		end
		wait_results(20, 2000, "shared ring");
		repeat (2 * MIX_STAGES) @(posedge clk); // catch duplicates
		check_eq("ring result count", res_q.size(), 20);
		check_eq("ring pop count", pop_cyc_q.size(), 20);
		foreach (res_q[r]) begin
			idx = res_q[r].job.block[7:0];
			if (idx >= 20 || jobs[idx].block != res_q[r].job.block) begin
				err_cnt++;
				$display("result with unknown block %h", res_q[r].job.block);
			end else if (seen[idx]) begin
				err_cnt++;
				$display("job %0d returned more than once", idx);
			end else begin
				seen[idx] = 1'b1;
				check_eq($sformatf("ring job %0d result_o", idx), res_q[r], exp_res[idx]);
				foreach (pop_blk_q[p]) begin
					if (pop_blk_q[p] == jobs[idx].block) begin
						check_eq($sformatf("ring job %0d latency", idx), res_cyc_q[r] - pop_cyc_q[p],
							exp_passes[idx] * MIX_STAGES + 1);
					end
				end
			end
		end
		for (int i = 0; i < 20; i++) begin
			if (!seen[i]) begin
				err_cnt++;
				$display("job %0d never returned a result", i);
			end
		end
	endtask

	initial begin
		repeat (16) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		test_idle_after_reset();
		test_budget_no_hit();
		test_full_mask_hit();
		test_partial_mask_hit();
		test_single_pass();
		test_shared_ring();
		repeat (4) @(posedge clk);
		$display("checks: %0d, errors: %0d", chk_cnt, err_cnt);
		if (err_cnt == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: files.f
+incdir+test
logic/search_cfg_pkg.sv
logic/search_types_pkg.sv
logic/mix_round_pipe.sv
logic/ctx_delay_line.sv
logic/loop_ctrl.sv
logic/key_search_top.sv
test/tb_key_search.sv

// File: Bender.yml
package:
  name: key_search

sources:
  - logic/search_cfg_pkg.sv
  - logic/search_types_pkg.sv
  - logic/mix_round_pipe.sv
  - logic/ctx_delay_line.sv
  - logic/loop_ctrl.sv
  - logic/key_search_top.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/tb_key_search.sv
